// File: ext_pkg.sv
// ======================================
// Extract stage package
// Widths, vector types, opcodes, group
// records and the step state encoding
// ======================================
package ext_pkg;

	// ======================================
	// Widths
	// ======================================
	// Slots per pipeline group
	localparam int MWIDTH = 4;
	localparam int PARCEL_W = 16;
	localparam int INSN_PARCELS = 3;
	// Each instruction is three parcels of two bytes
	localparam int INSN_BYTES = INSN_PARCELS * 2;
	localparam int INSN_W = INSN_PARCELS * PARCEL_W;
	localparam int LINE_PARCELS = 32;
	localparam int LINE_W = LINE_PARCELS * PARCEL_W;
	// Aligned window covers all slots of a group
	localparam int WIN_W = MWIDTH * INSN_W;

	// ======================================
	// Vector types
	// ======================================
	typedef logic [31:0] pc_t;
	// Opcode in 6:0, signed displacement or address in 47:16
	typedef logic [INSN_W-1:0] insn_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [WIN_W-1:0] win_t;
	typedef logic [5:0] ipl_t;
	typedef logic [MWIDTH-1:0] slot_mask_t;

	// Default target when nothing redirects
	localparam pc_t RST_PC = 32'h0000_0000;

	// Opcodes
	localparam logic [6:0] OP_NOP = 7'h0B;
	localparam logic [6:0] OP_BSR = 7'h20;
	localparam logic [6:0] OP_JSR = 7'h21;
	localparam logic [6:0] OP_BCC = 7'h28;
	localparam logic [6:0] OP_RET = 7'h2C;

	// Filler parcel for the part of the window past the line end
	localparam logic [PARCEL_W-1:0] NOP_PARCEL = {{(PARCEL_W-7){1'b0}}, OP_NOP};

	// ======================================
	// Group records
	// ======================================
	typedef struct packed {
		logic v;
		pc_t ip;
		insn_t insn;
		// Predictor taken bit
		logic bt;
	} slot_t;

	typedef struct packed {
		logic v;
		pc_t ip;
		logic irq;
		ipl_t ipl;
	} group_hdr_t;

	typedef struct packed {
		group_hdr_t hdr;
		slot_t [MWIDTH-1:0] slot;
	} group_t;

	typedef struct packed {
		logic do_bsr;
		logic do_call;
		logic do_ret;
		pc_t tgt;
		pc_t ret_pc;
	} flow_t;

	typedef enum logic {
		ST_RUN,
		ST_STEPPING
	} step_state_t;

	// PC of a slot, counted in instructions from the group PC
	function automatic pc_t fn_slot_pc(input pc_t pc, input int unsigned idx);
		return pc + pc_t'(INSN_BYTES * idx);
	endfunction

endpackage

// File: line_align.sv
// ======================================
// Line alignment
// Shifts the cache line onto the fetch
// PC parcel and flags a repeated group
// ======================================
module line_align (
	input  logic          clk,
	input  logic          rst_i,
	input  logic          en_i,
	input  ext_pkg::pc_t   pc_i,
	input  ext_pkg::line_t cline_i,
	output ext_pkg::win_t  win_o,
	output logic          redundant_o
);
	import ext_pkg::*;

	// Parcels needed past the line to fill a whole window
	localparam int PAD_PARCELS = WIN_W / PARCEL_W;
	localparam int PIDX_W = $clog2(LINE_PARCELS);

	logic [PIDX_W-1:0] pidx;
	logic [LINE_W+WIN_W-1:0] ext_line;
	logic [LINE_W+WIN_W-1:0] shifted;
	win_t win;

	// Copy of the last accepted group
	pc_t prev_pc;
	win_t prev_win;

	// Parcel index within the 64 byte line
	assign pidx = pc_i[PIDX_W:1];

	// ======================================
	// Alignment
	// ======================================
	always_comb begin
		// NOP parcels sit above the top of the line
		ext_line = {{PAD_PARCELS{NOP_PARCEL}}, cline_i};
		// Shift by parcel count times sixteen
		shifted = ext_line >> {pidx, 4'd0};
		win = shifted[WIN_W-1:0];
	end

	assign win_o = win;

	// ======================================
	// Redundant group detection
	// ======================================
	// Reset state is PC 0 with a zero line
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= RST_PC;
			prev_win <= '0;
		end else if (en_i) begin
			prev_pc <= pc_i;
			prev_win <= win;
		end
	end

	// Same PC and same window as last time means nothing new
	assign redundant_o = (prev_pc == pc_i) && (prev_win == win);

endmodule

// File: step_fsm.sv
// ======================================
// Single step control
// Tracks the step state and forms the
// per-slot valid mask
// ======================================
module step_fsm (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                en_i,
	input  logic                ssm_i,
	input  logic                irq_i,
	input  logic                stomp_i,
	input  logic                branchmiss_i,
	input  logic                redundant_i,
	input  ext_pkg::pc_t         miss_pc_i,
	input  ext_pkg::pc_t         pc_i,
	output ext_pkg::slot_mask_t  valid_o,
	output logic                group_v_o
);
	import ext_pkg::*;

	step_state_t state;
	step_state_t state_nxt;
	logic group_ok;

	// ======================================
	// State machine
	// ======================================
	always_comb begin
		state_nxt = state;
		case (state)
			// First cycle of a step lets slot 0 through
			ST_RUN: begin
				if (ssm_i)
					state_nxt = ST_STEPPING;
			end
			// Hold until the step request drops
			ST_STEPPING: begin
				if (!ssm_i)
					state_nxt = ST_RUN;
			end
			default: state_nxt = ST_RUN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			state <= ST_RUN;
		else if (en_i)
			state <= state_nxt;
	end

	// ======================================
	// Slot valid mask
	// ======================================
	// Interrupt, stomp or a repeated group kill everything
	assign group_ok = !irq_i && !stomp_i && !redundant_i;

	always_comb begin
		pc_t slot_pc;
		logic step_ok;
		logic miss_ok;
		for (int i = 0; i < MWIDTH; i++) begin
			slot_pc = fn_slot_pc(pc_i, i);
			step_ok = !ssm_i || (i == 0 && state == ST_RUN);
			// Slots before the miss PC are on the wrong path
			miss_ok = !branchmiss_i || (slot_pc >= miss_pc_i);
			valid_o[i] = group_ok && step_ok && miss_ok;
		end
	end

	assign group_v_o = !stomp_i;

endmodule

// File: branch_predecode.sv
// ======================================
// Branch pre-decode
// Classifies one instruction and forms
// its branch target
// ======================================
module branch_predecode (
	input  ext_pkg::pc_t   ip_i,
	input  ext_pkg::insn_t insn_i,
	output logic          call_o,
	output logic          bcc_o,
	output logic          ret_o,
	output ext_pkg::pc_t   tgt_o
);
	import ext_pkg::*;

	logic [6:0] opcode;
	// Displacement or absolute address
	pc_t field;

	assign opcode = insn_i[6:0];
	// Signed field spans the whole PC width
	assign field = insn_i[47:16];

	// Class bits
	assign call_o = (opcode == OP_BSR) || (opcode == OP_JSR);
	assign bcc_o = (opcode == OP_BCC);
	assign ret_o = (opcode == OP_RET);

	// Target
	always_comb begin
		case (opcode)
			// PC relative forms
			OP_BSR,
			OP_BCC: tgt_o = ip_i + field;
			// Absolute call
			OP_JSR: tgt_o = field;
			default: tgt_o = RST_PC;
		endcase
	end

endmodule

// File: flow_select.sv
// ======================================
// Flow selection
// Picks the first valid control-flow
// slot and its target and return PC
// ======================================
module flow_select (
	input  ext_pkg::slot_mask_t valid_i,
	input  ext_pkg::pc_t        pc_i,
	input  ext_pkg::win_t       win_i,
	output ext_pkg::flow_t      flow_o
);
	import ext_pkg::*;

	pc_t [MWIDTH-1:0] slot_ip;
	pc_t [MWIDTH-1:0] slot_tgt;
	logic [MWIDTH-1:0] is_call;
	logic [MWIDTH-1:0] is_bcc;
	logic [MWIDTH-1:0] is_ret;

	// One pre-decoder per slot
	for (genvar g = 0; g < MWIDTH; g++) begin : g_dec
		assign slot_ip[g] = fn_slot_pc(pc_i, g);

		branch_predecode i_dec (
			.ip_i   (slot_ip[g]),
			.insn_i (win_i[g*INSN_W +: INSN_W]),
			.call_o (is_call[g]),
			.bcc_o  (is_bcc[g]),
			.ret_o  (is_ret[g]),
			.tgt_o  (slot_tgt[g])
		);
	end

	// ======================================
	// Priority scan from slot 0 upward
	// ======================================
	always_comb begin
		logic found;
		logic call_seen;
		flow_o = '0;
		flow_o.tgt = RST_PC;
		flow_o.ret_pc = RST_PC;
		found = 1'b0;
		call_seen = 1'b0;
		for (int i = 0; i < MWIDTH; i++) begin
			if (valid_i[i] && !found) begin
				// Calls and branches redirect
				if (is_call[i] || is_bcc[i]) begin
					flow_o.do_bsr = 1'b1;
					flow_o.do_call = is_call[i];
					flow_o.tgt = slot_tgt[i];
					found = 1'b1;
				end else if (is_ret[i]) begin
					flow_o.do_ret = 1'b1;
					found = 1'b1;
				end
			end
			// Return address follows the first valid call
			if (valid_i[i] && is_call[i] && !call_seen) begin
				flow_o.ret_pc = fn_slot_pc(slot_ip[i], 1);
				call_seen = 1'b1;
			end
		end
	end

endmodule

// File: group_reg.sv
// ======================================
// Extract stage register
// Builds and holds the group record and
// the flow record
// ======================================
module group_reg (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  en_i,
	input  logic                  group_v_i,
	input  logic                  irq_i,
	input  logic [ext_pkg::MWIDTH-1:0] bt_i,
	input  ext_pkg::ipl_t          ipl_i,
	input  ext_pkg::pc_t           pc_i,
	input  ext_pkg::win_t          win_i,
	input  ext_pkg::slot_mask_t    valid_i,
	input  ext_pkg::flow_t         flow_i,
	output ext_pkg::group_t        group_o,
	output ext_pkg::flow_t         flow_o
);
	import ext_pkg::*;

	group_t group_d;
	group_t group_q;
	flow_t flow_q;

	// ======================================
	// Group record assembly
	// ======================================
	always_comb begin
		group_d.hdr.v = group_v_i;
		group_d.hdr.ip = pc_i;
		group_d.hdr.irq = irq_i;
		group_d.hdr.ipl = ipl_i;
		for (int i = 0; i < MWIDTH; i++) begin
			group_d.slot[i].v = valid_i[i];
			group_d.slot[i].ip = fn_slot_pc(pc_i, i);
			group_d.slot[i].insn = win_i[i*INSN_W +: INSN_W];
			group_d.slot[i].bt = bt_i[i];
		end
	end

	// ======================================
	// Stage register
	// ======================================
	// Reset clears the valid and do bits only
	always_ff @(posedge clk) begin
		if (rst_i) begin
			group_q.hdr.v <= 1'b0;
			for (int i = 0; i < MWIDTH; i++)
				group_q.slot[i].v <= 1'b0;
			flow_q.do_bsr <= 1'b0;
			flow_q.do_call <= 1'b0;
			flow_q.do_ret <= 1'b0;
		end else if (en_i) begin
			group_q <= group_d;
			flow_q <= flow_i;
		end
	end

	assign group_o = group_q;
	assign flow_o = flow_q;

endmodule

// File: pipeline_ext_top.sv
// ======================================
// Extract stage top level
// Aligns a fetched line into a group of
// slots with validity and pre-decode
// ======================================
module pipeline_ext_top (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  en_i,
	input  logic                  stomp_i,
	input  logic                  irq_i,
	input  logic                  ssm_i,
	input  logic                  branchmiss_i,
	input  logic [ext_pkg::MWIDTH-1:0] bt_i,
	input  ext_pkg::ipl_t          ipl_i,
	input  ext_pkg::pc_t           pc_i,
	input  ext_pkg::pc_t           miss_pc_i,
	input  ext_pkg::line_t         cline_i,
	output ext_pkg::group_t        group_o,
	output ext_pkg::flow_t         flow_o
);
	import ext_pkg::*;

	// Aligned window and repeat flag
	win_t win;
	logic redundant;
	// Slot validity
	slot_mask_t valid;
	logic group_v;
	// Next flow record
	flow_t flow_d;

	line_align i_align (
		.clk         (clk),
		.rst_i       (rst_i),
		.en_i        (en_i),
		.pc_i        (pc_i),
		.cline_i     (cline_i),
		.win_o       (win),
		.redundant_o (redundant)
	);

	step_fsm i_step (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.ssm_i        (ssm_i),
		.irq_i        (irq_i),
		.stomp_i      (stomp_i),
		.branchmiss_i (branchmiss_i),
		.redundant_i  (redundant),
		.miss_pc_i    (miss_pc_i),
		.pc_i         (pc_i),
		.valid_o      (valid),
		.group_v_o    (group_v)
	);

	flow_select i_flow (
		.valid_i (valid),
		.pc_i    (pc_i),
		.win_i   (win),
		.flow_o  (flow_d)
	);

	group_reg i_reg (
		.clk       (clk),
		.rst_i     (rst_i),
		.en_i      (en_i),
		.group_v_i (group_v),
		.irq_i     (irq_i),
		.bt_i      (bt_i),
		.ipl_i     (ipl_i),
		.pc_i      (pc_i),
		.win_i     (win),
		.valid_i   (valid),
		.flow_i    (flow_d),
		.group_o   (group_o),
		.flow_o    (flow_o)
	);

endmodule

// File: tb_pipeline_ext_top.sv
// ======================================
// Extract stage testbench
// Directed tests checked against a model
// of alignment, validity and pre-decode
// ======================================
module tb_pipeline_ext_top;
	import ext_pkg::*;

	// One group of fetch inputs
	typedef struct packed {
		pc_t pc;
		line_t line;
		logic irq;
		logic stomp;
		logic ssm;
		logic bmiss;
		pc_t miss_pc;
		logic [MWIDTH-1:0] bt;
		ipl_t ipl;
	} stim_t;

	localparam int CLK_HALF = 20;
	// Each accepted group takes two cycles
	localparam int NUM_GROUPS = 28;
	localparam int TEST_CYCLES = 2 * NUM_GROUPS + 8;
	localparam int MARGIN_CYCLES = 40;

	logic clk;
	logic rst_i;
	logic en_i;
	logic stomp_i;
	logic irq_i;
	logic ssm_i;
	logic branchmiss_i;
	logic [MWIDTH-1:0] bt_i;
	ipl_t ipl_i;
	pc_t pc_i;
	pc_t miss_pc_i;
	line_t cline_i;
	group_t group_o;
	flow_t flow_o;

	// Reference model state that follows accepted groups only
	pc_t m_prev_pc;
	win_t m_prev_win;
	logic m_stepping;
	int errors;
	int checks;

	pipeline_ext_top i_dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.stomp_i      (stomp_i),
		.irq_i        (irq_i),
		.ssm_i        (ssm_i),
		.branchmiss_i (branchmiss_i),
		.bt_i         (bt_i),
		.ipl_i        (ipl_i),
		.pc_i         (pc_i),
		.miss_pc_i    (miss_pc_i),
		.cline_i      (cline_i),
		.group_o      (group_o),
		.flow_o       (flow_o)
	);

	always #CLK_HALF clk = ~clk;

	// ======================================
	// Reference model
	// ======================================
	// Window starts at parcel pc[5:1] with NOP parcels past the line end
	function automatic win_t align_line(input pc_t pc, input line_t line);
		win_t w;
		int idx;
		for (int p = 0; p < WIN_W / PARCEL_W; p++) begin
			idx = int'(pc[5:1]) + p;
			if (idx < LINE_PARCELS)
				w[p*PARCEL_W +: PARCEL_W] = line[idx*PARCEL_W +: PARCEL_W];
			else
				w[p*PARCEL_W +: PARCEL_W] = {9'd0, OP_NOP};
		end
		return w;
	endfunction

	function automatic slot_mask_t expect_valid(input stim_t s, input logic redundant);
		slot_mask_t v;
		pc_t ip;
		logic step_ok;
		logic miss_ok;
		for (int i = 0; i < MWIDTH; i++) begin
			ip = s.pc + 6 * i;
			// Only slot 0 in the first cycle of a step
			step_ok = !s.ssm || (i == 0 && !m_stepping);
			miss_ok = !s.bmiss || (ip >= s.miss_pc);
			v[i] = !s.irq && !s.stomp && !redundant && step_ok && miss_ok;
		end
		return v;
	endfunction

	function automatic flow_t expect_flow(input pc_t pc, input win_t w, input slot_mask_t v);
		flow_t f;
		insn_t insn;
		pc_t ip;
		logic [6:0] op;
		logic found;
		logic call_seen;
		f = '0;
		f.tgt = RST_PC;
		f.ret_pc = RST_PC;
		found = 1'b0;
		call_seen = 1'b0;
		for (int i = 0; i < MWIDTH; i++) begin
			insn = w[i*INSN_W +: INSN_W];
			op = insn[6:0];
			ip = pc + 6 * i;
			if (v[i] && !found) begin
				if (op == OP_BSR || op == OP_BCC) begin
					f.do_bsr = 1'b1;
					f.do_call = (op == OP_BSR);
					f.tgt = ip + insn[47:16];
					found = 1'b1;
				end else if (op == OP_JSR) begin
					f.do_bsr = 1'b1;
					f.do_call = 1'b1;
					f.tgt = insn[47:16];
					found = 1'b1;
				end else if (op == OP_RET) begin
					f.do_ret = 1'b1;
					found = 1'b1;
				end
			end
			// Return PC of the first valid call
			if (v[i] && !call_seen && (op == OP_BSR || op == OP_JSR)) begin
				f.ret_pc = ip + 32'd6;
				call_seen = 1'b1;
			end
		end
		return f;
	endfunction

	// ======================================
	// Stimulus helpers
	// ======================================
	function automatic insn_t make_insn(input logic [6:0] op, input pc_t field);
		return {field, 9'd0, op};
	endfunction

	// Parcels that fall past the line end are dropped
	function automatic line_t put_insn(input line_t line, input int p, input insn_t insn);
		line_t l;
		l = line;
		for (int k = 0; k < INSN_PARCELS; k++)
			if (p + k < LINE_PARCELS)
				l[(p+k)*PARCEL_W +: PARCEL_W] = insn[k*PARCEL_W +: PARCEL_W];
		return l;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int w = 0; w < LINE_W / 32; w++)
			l[w*32 +: 32] = $urandom;
		return l;
	endfunction

	function automatic pc_t random_pc(input logic [5:0] off);
		logic [31:0] r;
		r = $urandom;
		return {r[31:6], off};
	endfunction

	// No invalidation, random taken bits and level
	function automatic stim_t quiet_stim(input pc_t pc, input line_t line);
		stim_t s;
		logic [31:0] r;
		r = $urandom;
		s = '0;
		s.pc = pc;
		s.line = line;
		s.bt = r[3:0];
		s.ipl = r[9:4];
		return s;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	// Drive one group, accept it, then check the registered result
	task automatic send_group(input stim_t s);
		win_t w;
		logic redundant;
		slot_mask_t v;
		flow_t f;
		w = align_line(s.pc, s.line);
		redundant = (s.pc == m_prev_pc) && (w == m_prev_win);
		v = expect_valid(s, redundant);
		f = expect_flow(s.pc, w, v);
		@(posedge clk);
		en_i <= 1'b1;
		pc_i <= s.pc;
		cline_i <= s.line;
		irq_i <= s.irq;
		stomp_i <= s.stomp;
		ssm_i <= s.ssm;
		branchmiss_i <= s.bmiss;
		miss_pc_i <= s.miss_pc;
		bt_i <= s.bt;
		ipl_i <= s.ipl;
		@(posedge clk);
		en_i <= 1'b0;
		@(negedge clk);
		check_value("group_o.hdr.v", 64'(group_o.hdr.v), 64'(!s.stomp));
		check_value("group_o.hdr.ip", 64'(group_o.hdr.ip), 64'(s.pc));
		check_value("group_o.hdr.irq", 64'(group_o.hdr.irq), 64'(s.irq));
		check_value("group_o.hdr.ipl", 64'(group_o.hdr.ipl), 64'(s.ipl));
		for (int i = 0; i < MWIDTH; i++) begin
			check_value($sformatf("group_o.slot[%0d].v", i),
				64'(group_o.slot[i].v), 64'(v[i]));
			check_value($sformatf("group_o.slot[%0d].ip", i),
				64'(group_o.slot[i].ip), 64'(s.pc + 6 * i));
			check_value($sformatf("group_o.slot[%0d].insn", i),
				64'(group_o.slot[i].insn), 64'(w[i*INSN_W +: INSN_W]));
			check_value($sformatf("group_o.slot[%0d].bt", i),
				64'(group_o.slot[i].bt), 64'(s.bt[i]));
		end
		check_value("flow_o.do_bsr", 64'(flow_o.do_bsr), 64'(f.do_bsr));
		check_value("flow_o.do_call", 64'(flow_o.do_call), 64'(f.do_call));
		check_value("flow_o.do_ret", 64'(flow_o.do_ret), 64'(f.do_ret));
		check_value("flow_o.tgt", 64'(flow_o.tgt), 64'(f.tgt));
		check_value("flow_o.ret_pc", 64'(flow_o.ret_pc), 64'(f.ret_pc));
		m_prev_pc = s.pc;
		m_prev_win = w;
		m_stepping = s.ssm;
	endtask

	// ======================================
	// Directed tests
	// ======================================
	task automatic test_alignment();
		for (int n = 0; n < 6; n++)
			send_group(quiet_stim(random_pc(6'($urandom) & 6'h3e), random_line()));
		// Offsets near the line end pull in NOP padding
		for (int n = 0; n < 4; n++)
			send_group(quiet_stim(random_pc(6'h3e - 6'(4 * n)), random_line()));
	endtask

	task automatic test_invalidation();
		stim_t s;
		s = quiet_stim(random_pc(6'h10), random_line());
		s.irq = 1'b1;
		send_group(s);
		s = quiet_stim(random_pc(6'h04), random_line());
		s.stomp = 1'b1;
		send_group(s);
		// Slots 0 and 1 sit below the miss PC
		s = quiet_stim(random_pc(6'h08), random_line());
		s.bmiss = 1'b1;
		s.miss_pc = s.pc + 32'd8;
		send_group(s);
		s = quiet_stim(random_pc(6'h08), random_line());
		s.bmiss = 1'b1;
		s.miss_pc = s.pc - 32'd2;
		send_group(s);
	endtask

	task automatic test_single_step();
		stim_t s;
		for (int n = 0; n < 3; n++) begin
			s = quiet_stim(random_pc(6'h00), random_line());
			s.ssm = 1'b1;
			send_group(s);
		end
		send_group(quiet_stim(random_pc(6'h00), random_line()));
	endtask

	task automatic test_redundant();
		stim_t s;
		s = quiet_stim(random_pc(6'h0c), random_line());
		send_group(s);
		send_group(s);
		s.line = random_line();
		send_group(s);
		s.pc = s.pc + 32'd2;
		send_group(s);
	endtask

	task automatic test_flow();
		stim_t s;
		// Branch in slot 1 wins, call in slot 2 gives the return PC
		s = quiet_stim(random_pc(6'h00), '0);
		s.line = put_insn(s.line, 3, make_insn(OP_BCC, 32'h0000_0100));
		s.line = put_insn(s.line, 6, make_insn(OP_BSR, 32'hffff_ffc0));
		s.line = put_insn(s.line, 9, make_insn(OP_RET, 32'h0));
		send_group(s);
		// Return first, absolute call after it
		s = quiet_stim(random_pc(6'h00), '0);
		s.line = put_insn(s.line, 0, make_insn(OP_RET, 32'h0));
		s.line = put_insn(s.line, 3, make_insn(OP_JSR, 32'h8000_1234));
		send_group(s);
		// Call in slot 0 lost to a branch miss
		s = quiet_stim(random_pc(6'h00), '0);
		s.line = put_insn(s.line, 0, make_insn(OP_JSR, 32'h0000_4000));
		s.line = put_insn(s.line, 3, make_insn(OP_BSR, 32'hffff_ffe0));
		s.bmiss = 1'b1;
		s.miss_pc = s.pc + 32'd6;
		send_group(s);
		// Branch in the last parcels of the line
		s = quiet_stim(random_pc(6'h3a), random_line());
		s.line = put_insn(s.line, 29, make_insn(OP_BCC, 32'h0000_0040));
		send_group(s);
	endtask

	task automatic test_hold();
		stim_t s;
		group_t g;
		flow_t f;
		s = quiet_stim(random_pc(6'h20), random_line());
		send_group(s);
		g = group_o;
		f = flow_o;
		for (int n = 0; n < 3; n++) begin
			@(posedge clk);
			pc_i <= random_pc(6'h14);
			cline_i <= random_line();
			irq_i <= ~irq_i;
			bt_i <= ~bt_i;
			@(negedge clk);
			checks++;
			if (group_o !== g || flow_o !== f) begin
				errors++;
				$display("error t=%0t group_o/flow_o got %h/%h exp %h/%h",
					$time, group_o, flow_o, g, f);
			end
		end
		// Previous-group copy kept the group from before the pause
		send_group(s);
	endtask

	// ======================================
	// Main sequence and watchdog
	// ======================================
	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * 2 * CLK_HALF);
		$display("watchdog timeout, the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'hf5be));
		clk = 1'b0;
		rst_i = 1'b1;
		en_i = 1'b0;
		stomp_i = 1'b0;
		irq_i = 1'b0;
		ssm_i = 1'b0;
		branchmiss_i = 1'b0;
		bt_i = '0;
		ipl_i = '0;
		pc_i = '0;
		miss_pc_i = '0;
		cline_i = '0;
		errors = 0;
		checks = 0;
		m_prev_pc = RST_PC;
		m_prev_win = '0;
		m_stepping = 1'b0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		check_value("group_o.hdr.v after reset", 64'(group_o.hdr.v), 64'(0));
		for (int i = 0; i < MWIDTH; i++)
			check_value($sformatf("group_o.slot[%0d].v after reset", i),
				64'(group_o.slot[i].v), 64'(0));
		check_value("flow_o do bits after reset",
			64'({flow_o.do_bsr, flow_o.do_call, flow_o.do_ret}), 64'(0));
		test_alignment();
		test_invalidation();
		test_single_step();
		test_redundant();
		test_flow();
		test_hold();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: pipeline_ext_top.f
ext_pkg.sv
line_align.sv
step_fsm.sv
branch_predecode.sv
flow_select.sv
group_reg.sv
pipeline_ext_top.sv
tb_pipeline_ext_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the extract stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f pipeline_ext_top.f \
	--top-module tb_pipeline_ext_top --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
